// File: hw/ast_clk_pkg.sv
/*
  Shared clock-source types: oscillator index, clock and flag vectors,
  default divider, enable delay and jitter seed constants
*/

package ast_clk_pkg;

  ////////////////////
  // Oscillator index
  ////////////////////

  // Bit position of each source inside the 4-bit vectors below
  typedef enum logic [1:0] {
    OSC_SYS = 2'd0,  // System clock, jitter capable
    OSC_IO  = 2'd1,  // Peripheral io clock
    OSC_USB = 2'd2,  // USB clock
    OSC_AON = 2'd3   // Always-on clock, first up
  } osc_id_e;

  ////////////////////
  // Vector types
  ////////////////////

  // One clock per source, MSB first so sys lands on bit 0
  typedef struct packed {
    logic aon;  // Bit 3
    logic usb;  // Bit 2
    logic io;   // Bit 1
    logic sys;  // Bit 0
  } osc_clks_t;

  // Per-source flag, same layout as osc_clks_t
  // Carries enables towards the models and valids back
  typedef struct packed {
    logic aon;
    logic usb;
    logic io;
    logic sys;
  } osc_vec_t;

  ////////////////////
  // Defaults
  ////////////////////

  // Half periods in external clock cycles
  parameter int DefSysDiv = 1;   // Fastest, ext/2
  parameter int DefIoDiv  = 2;   // ext/4
  parameter int DefUsbDiv = 4;   // ext/8
  parameter int DefAonDiv = 32;  // Slow always-on tick

  // Cycles from a granted enable to the first toggle
  // Stands in for the analog RC start-up delay
  parameter int DefEnRdly = 8;

  // Jitter LFSR start value, must be non-zero
  parameter logic [15:0] DefLfsrSeed = 16'hace1;

endpackage : ast_clk_pkg

// File: hw/jitter_lfsr.sv
/*
  16-bit Fibonacci LFSR giving sparse one-cycle stretch requests
*/

`timescale 1ns/1ps

module jitter_lfsr #(
  parameter logic [15:0] Seed = ast_clk_pkg::DefLfsrSeed  // Non-zero start
) (
  input  logic clk_sys_ext_i,  // External reference clock
  input  logic reset_i,        // Sync reset, active high
  output logic stretch_o       // One-cycle stretch pulse
);

  logic [15:0] lfsr_q;
  logic        fb;             // Feedback bit
  logic        stretch_q;
  logic        hit;            // Low two bits both set

  // Taps 16,14,13,11, maximal length
  assign fb  = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  assign hit = &lfsr_q[1:0];

  always_ff @(posedge clk_sys_ext_i) begin
    if (reset_i) begin
      lfsr_q    <= Seed;
      stretch_q <= 1'b0;
    end else begin
      lfsr_q    <= {lfsr_q[14:0], fb};  // Shift every cycle
      // Back-to-back hits give one pulse only
      stretch_q <= hit & ~stretch_q;
    end
  end

  assign stretch_o = stretch_q;

endmodule : jitter_lfsr

// File: hw/osc_gen.sv
/*
  Oscillator model: enable rise delay, half-period divider with optional
  jitter stretch, glitch-free stop at low phase and valid flag
*/

`timescale 1ns/1ps

module osc_gen #(
  parameter int Div    = ast_clk_pkg::DefSysDiv,  // Half period, ext cycles
  parameter int EnRdly = ast_clk_pkg::DefEnRdly   // Enable to first toggle
) (
  input  logic clk_sys_ext_i,  // External reference clock
  input  logic reset_i,        // Sync reset, active high
  input  logic vcore_pok_h_i,  // Core power good
  input  logic en_i,           // Enable level from the sequencer
  input  logic jen_i,          // Jitter enable
  input  logic stretch_i,      // Stretch request pulse
  output logic clk_o,          // Divided clock
  output logic val_o           // Clock running
);

  ////////////////////
  // Widths and loads
  ////////////////////

  localparam int HalfW = $clog2(Div + 1);     // Holds Div for stretched halves
  localparam int DlyW  = $clog2(EnRdly + 1);

  localparam logic [HalfW-1:0] HalfLoad  = HalfW'(Div - 1);  // Div cycles
  localparam logic [HalfW-1:0] HalfLoadJ = HalfW'(Div);      // Div+1 cycles
  localparam logic [DlyW-1:0]  DlyLoad   = DlyW'(EnRdly - 1);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // Off, output low
    DELAY = 2'd1,  // Counting the start-up delay
    RUN   = 2'd2,  // Toggling
    STOP  = 2'd3   // Disabled while high, finishing the half period
  } osc_state_e;

  osc_state_e       state_q;
  logic [DlyW-1:0]  dly_cnt_q;   // Rise delay down-counter
  logic [HalfW-1:0] half_cnt_q;  // Cycles left in current half period
  logic             clk_q;       // Output flop

  logic             half_done;
  logic             stretch_ok;
  logic [HalfW-1:0] half_load;

  ////////////////////
  // Half-period reload
  ////////////////////

  assign half_done  = (half_cnt_q == '0);
  assign stretch_ok = jen_i & stretch_i;  // Tied off except on sys
  // Stretch is taken at a toggle and lengthens the half that follows
  assign half_load  = stretch_ok ? HalfLoadJ : HalfLoad;

  ////////////////////
  // Oscillator FSM
  ////////////////////

  always_ff @(posedge clk_sys_ext_i) begin
    if (reset_i || !vcore_pok_h_i) begin
      state_q <= IDLE;  // Power-down stops at once
      clk_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (en_i) begin
            state_q   <= DELAY;
            dly_cnt_q <= DlyLoad;
          end
        end
        DELAY: begin
          if (!en_i) begin
            state_q <= IDLE;           // Next rise restarts the count
          end else if (dly_cnt_q == '0) begin
            state_q    <= RUN;
            clk_q      <= 1'b1;        // First toggle, valid with it
            half_cnt_q <= half_load;
          end else begin
            dly_cnt_q <= dly_cnt_q - 1'b1;
          end
        end
        RUN: begin
          if (!en_i && !clk_q) begin
            state_q <= IDLE;           // Low phase, stop now
          end else if (half_done) begin
            clk_q      <= ~clk_q;
            half_cnt_q <= half_load;
            if (!en_i) begin
              state_q <= IDLE;         // Was high, this edge takes it low
            end
          end else begin
            half_cnt_q <= half_cnt_q - 1'b1;
            if (!en_i) begin
              state_q <= STOP;         // High, let the half period end
            end
          end
        end
        STOP: begin
          // Output is high here
          if (half_done) begin
            clk_q   <= 1'b0;
            state_q <= IDLE;
          end else begin
            half_cnt_q <= half_cnt_q - 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
          clk_q   <= 1'b0;
        end
      endcase
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign clk_o = clk_q;
  assign val_o = (state_q == RUN) || (state_q == STOP);  // Falls as clock stops

endmodule : osc_gen

// File: hw/osc_ctrl.sv
/*
  Clock-source sequencer: power-good wait, aon bring-up, then
  pass-through of sys/io/usb enables and ready generation
*/

`timescale 1ns/1ps

module osc_ctrl (
  input  logic                 clk_sys_ext_i,  // External reference clock
  input  logic                 reset_i,        // Sync reset, active high
  input  logic                 vcore_pok_h_i,  // Core power good
  input  logic                 sys_en_i,       // Sys clock request
  input  logic                 io_en_i,        // Io clock request
  input  logic                 usb_en_i,       // Usb clock request
  input  ast_clk_pkg::osc_vec_t osc_val_i,     // Valids from the models
  output ast_clk_pkg::osc_vec_t osc_en_o,      // Enables to the models
  output logic                 ast_ready_o     // All enabled sources up
);

  import ast_clk_pkg::*;

  ////////////////////
  // State and flops
  ////////////////////

  typedef enum logic [1:0] {
    POK_WAIT = 2'd0,  // Power not good, all off
    AON_UP   = 2'd1,  // Aon only, waiting for its valid
    RUN      = 2'd2   // Requests passed through
  } ctrl_state_e;

  ctrl_state_e state_q;
  osc_vec_t    osc_en_q;  // Registered enables
  logic        ready_q;

  // Next-enable candidates
  osc_vec_t aon_only;
  osc_vec_t req_en;

  // Plain vectors so the source enum can index them
  logic [3:0] en_bits;
  logic [3:0] val_bits;
  logic       ena_match;  // Every sys/io/usb enable matches its valid
  logic       ready_d;

  ////////////////////
  // Combinational
  ////////////////////

  always_comb begin
    aon_only     = '0;
    aon_only.aon = 1'b1;   // Aon alone during bring-up

    req_en       = '0;
    req_en.aon   = 1'b1;   // Aon never drops while power is good
    req_en.sys   = sys_en_i;
    req_en.io    = io_en_i;
    req_en.usb   = usb_en_i;
  end

  assign en_bits  = osc_en_q;
  assign val_bits = osc_val_i;

  // A source still stopping (valid, no enable) or still starting
  // (enable, no valid) holds ready low
  assign ena_match = (en_bits[OSC_SYS] == val_bits[OSC_SYS]) &&
                     (en_bits[OSC_IO]  == val_bits[OSC_IO])  &&
                     (en_bits[OSC_USB] == val_bits[OSC_USB]);

  assign ready_d = (state_q == RUN) && val_bits[OSC_AON] && ena_match;

  ////////////////////
  // Sequencer
  ////////////////////

  always_ff @(posedge clk_sys_ext_i) begin
    if (reset_i || !vcore_pok_h_i) begin
      // Power loss from any state lands here
      state_q  <= POK_WAIT;
      osc_en_q <= '0;
      ready_q  <= 1'b0;
    end else begin
      ready_q <= ready_d;
      case (state_q)
        POK_WAIT: begin
          state_q  <= AON_UP;    // Pok seen high
          osc_en_q <= aon_only;
        end
        AON_UP: begin
          if (val_bits[OSC_AON]) begin
            state_q  <= RUN;
            osc_en_q <= req_en;  // First pass-through
          end
        end
        RUN: begin
          osc_en_q <= req_en;    // One cycle request to enable
        end
        default: begin
          state_q  <= POK_WAIT;
          osc_en_q <= '0;
        end
      endcase
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign osc_en_o = osc_en_q;

  // Drops together with aon valid, not a cycle later
  assign ast_ready_o = ready_q & val_bits[OSC_AON];

endmodule : osc_ctrl

// File: hw/ast_clks.sv
/*
  Clock-source top: sequencer, jitter source and the four oscillator
  models for sys, io, usb and aon
*/

`timescale 1ns/1ps

module ast_clks #(
  parameter int          SysDiv   = ast_clk_pkg::DefSysDiv,
  parameter int          IoDiv    = ast_clk_pkg::DefIoDiv,
  parameter int          UsbDiv   = ast_clk_pkg::DefUsbDiv,
  parameter int          AonDiv   = ast_clk_pkg::DefAonDiv,
  parameter int          EnRdly   = ast_clk_pkg::DefEnRdly,   // Same for all models
  parameter logic [15:0] LfsrSeed = ast_clk_pkg::DefLfsrSeed
) (
  input  logic                   clk_sys_ext_i,  // External reference clock
  input  logic                   reset_i,        // Sync reset, active high
  input  logic                   vcore_pok_h_i,  // Core power good
  input  logic                   sys_en_i,       // Sys clock request
  input  logic                   sys_jen_i,      // Sys jitter enable
  input  logic                   io_en_i,        // Io clock request
  input  logic                   usb_en_i,       // Usb clock request
  output ast_clk_pkg::osc_clks_t clk_src_o,      // Generated clocks
  output ast_clk_pkg::osc_vec_t  clk_val_o,      // Per-clock valid
  output logic                   ast_ready_o     // All enabled clocks up
);

  import ast_clk_pkg::*;

  osc_vec_t osc_en;   // Sequencer to models
  osc_vec_t osc_val;  // Models back to sequencer
  logic     stretch;  // Jitter request, sys only

  ////////////////////
  // Sequencer
  ////////////////////

  osc_ctrl u_osc_ctrl (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .sys_en_i      ( sys_en_i ),
    .io_en_i       ( io_en_i ),
    .usb_en_i      ( usb_en_i ),
    .osc_val_i     ( osc_val ),
    .osc_en_o      ( osc_en ),
    .ast_ready_o   ( ast_ready_o )
  );

  jitter_lfsr #(.Seed(LfsrSeed)) u_jitter_lfsr (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .stretch_o     ( stretch )
  );

  ////////////////////
  // Oscillators
  ////////////////////

  osc_gen #(.Div(SysDiv), .EnRdly(EnRdly)) u_sys_osc (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .en_i          ( osc_en.sys ),
    .jen_i         ( sys_jen_i ),  // Only jittered source
    .stretch_i     ( stretch ),
    .clk_o         ( clk_src_o.sys ),
    .val_o         ( osc_val.sys )
  );

  osc_gen #(.Div(IoDiv), .EnRdly(EnRdly)) u_io_osc (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .en_i          ( osc_en.io ),
    .jen_i         ( 1'b0 ),
    .stretch_i     ( 1'b0 ),
    .clk_o         ( clk_src_o.io ),
    .val_o         ( osc_val.io )
  );

  osc_gen #(.Div(UsbDiv), .EnRdly(EnRdly)) u_usb_osc (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .en_i          ( osc_en.usb ),
    .jen_i         ( 1'b0 ),
    .stretch_i     ( 1'b0 ),
    .clk_o         ( clk_src_o.usb ),
    .val_o         ( osc_val.usb )
  );

  osc_gen #(.Div(AonDiv), .EnRdly(EnRdly)) u_aon_osc (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .en_i          ( osc_en.aon ),
    .jen_i         ( 1'b0 ),
    .stretch_i     ( 1'b0 ),
    .clk_o         ( clk_src_o.aon ),
    .val_o         ( osc_val.aon )
  );

  assign clk_val_o = osc_val;

endmodule : ast_clks

// File: bench/ast_clks_assertions.sv
/*
  Concurrent checks on one oscillator model: power-down, stop phase,
  valid ordering and reset state
*/

`timescale 1ns/1ps

module osc_gen_assertions (
  input logic clk_sys_ext_i,  // External reference clock
  input logic reset_i,        // Sync reset, active high
  input logic vcore_pok_h_i,  // Core power good
  input logic en_i,           // Model enable
  input logic clk_i,          // Model output clock
  input logic val_i           // Model valid
);

  // Power down, everything low one edge later
  a_pd_off: assert property (@(posedge clk_sys_ext_i)
    !vcore_pok_h_i |=> (!clk_i && !val_i))
    else $error("output or valid active after power down");

  a_reset_off: assert property (@(posedge clk_sys_ext_i)
    reset_i |=> (!clk_i && !val_i))
    else $error("output or valid active after reset");

  // Stop lands on a low output
  a_stop_low: assert property (@(posedge clk_sys_ext_i)
    disable iff (reset_i || !vcore_pok_h_i)
    $fell(val_i) |-> !clk_i)
    else $error("valid fell with the output high");

  // Low phase and no enable, stops at once
  a_low_stop_now: assert property (@(posedge clk_sys_ext_i)
    disable iff (reset_i || !vcore_pok_h_i)
    (val_i && !clk_i && !en_i) |=> !val_i)
    else $error("low output kept running after disable");

  a_val_with_toggle: assert property (@(posedge clk_sys_ext_i)
    disable iff (reset_i)
    $rose(val_i) |-> $rose(clk_i))  // Valid only with the first toggle
    else $error("valid rose without a first toggle");

endmodule : osc_gen_assertions

// File: bench/ast_clks_tb.sv
/*
  Testbench for the clock-source top: power-down state, bring-up order,
  divider rates, glitch-free stop, jitter range and power loss
*/

`timescale 1ns/1ps

module ast_clks_tb;

  import ast_clk_pkg::*;

  ////////////////////
  // Setup
  ////////////////////

  localparam int          SysDiv    = 1;
  localparam int          IoDiv     = 2;
  localparam int          UsbDiv    = 4;
  localparam int          AonDiv    = 32;
  localparam int          EnRdly    = 8;
  localparam logic [15:0] LfsrSeed  = 16'hace1;
  localparam int          ClkPeriod = 8;               // ns
  localparam int          Win       = 256;             // Rate window, ext cycles
  localparam int          PdCycles  = 32;              // Powered-down hold
  localparam int          StartLim  = 4 * EnRdly + 16; // Bring-up budget
  localparam int          WaitLim   = 64;
  localparam int          NumDrops  = 4;
  // All test windows summed, plus margin
  localparam int WdCycles = 16 + PdCycles + 2 * StartLim + 2 * Win +
                            NumDrops * (16 + 4 * WaitLim) + 8 + 200;

  logic      clk_sys_ext_i = 1'b0;
  logic      reset_i;
  logic      vcore_pok_h_i;
  logic      sys_en_i;
  logic      sys_jen_i;
  logic      io_en_i;
  logic      usb_en_i;
  osc_clks_t clk_src_o;
  osc_vec_t  clk_val_o;
  logic      ast_ready_o;

  int     n_checks;
  int     n_errors;
  int     test_err;          // Error count when the test began
  integer seed = 32'hb3c9;

  always #(ClkPeriod / 2) clk_sys_ext_i = ~clk_sys_ext_i;

  ast_clks #(
    .SysDiv(SysDiv), .IoDiv(IoDiv), .UsbDiv(UsbDiv), .AonDiv(AonDiv),
    .EnRdly(EnRdly), .LfsrSeed(LfsrSeed)
  ) UUT (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .sys_en_i      ( sys_en_i ),
    .sys_jen_i     ( sys_jen_i ),
    .io_en_i       ( io_en_i ),
    .usb_en_i      ( usb_en_i ),
    .clk_src_o     ( clk_src_o ),
    .clk_val_o     ( clk_val_o ),
    .ast_ready_o   ( ast_ready_o )
  );

  bind osc_gen osc_gen_assertions u_osc_sva (
    .clk_sys_ext_i ( clk_sys_ext_i ),
    .reset_i       ( reset_i ),
    .vcore_pok_h_i ( vcore_pok_h_i ),
    .en_i          ( en_i ),
    .clk_i         ( clk_o ),
    .val_i         ( val_o )
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Half period per bit of osc_clks_t
  function automatic int div_of(int idx);
    int d;
    case (idx)
      0:       d = SysDiv;
      1:       d = IoDiv;
      2:       d = UsbDiv;
      default: d = AonDiv;
    endcase
    return d;
  endfunction

  // Rising edges in ncyc cycles at half period div
  function automatic int exp_edges(int div, int ncyc);
    return ncyc / (2 * div);
  endfunction

  // Falling-edge count from pok high to first toggle
  function automatic int exp_first(int idx);
    int aon;
    aon = EnRdly + 2;          // Grant edge, seen next edge, then EnRdly
    if (idx == 3)
      return aon;
    return aon + EnRdly + 2;   // Others granted the edge after aon valid
  endfunction

  ////////////////////
  // Edge counter
  ////////////////////

  logic [3:0] clk_bits;
  logic [3:0] val_bits;
  logic [3:0] prev_bits = '0;
  int         edge_cnt [4];  // Rising edges per source
  int         run_len  [4];  // Samples since last change
  int         short_hi [4];  // High pulses under Div
  int         stretched;     // Sys halves of 2 cycles
  int         long_half;     // Sys halves over 2 cycles

  assign clk_bits = clk_src_o;
  assign val_bits = clk_val_o;

  // Mid-cycle sampling, outputs settled since the rising edge
  always @(negedge clk_sys_ext_i) begin
    for (int i = 0; i < 4; i++) begin
      if (clk_bits[i] != prev_bits[i]) begin
        if (clk_bits[i])
          edge_cnt[i] <= edge_cnt[i] + 1;
        if (prev_bits[i] && run_len[i] < div_of(i))
          short_hi[i] <= short_hi[i] + 1;  // Runt high pulse
        if (i == 0 && run_len[i] == 2)
          stretched <= stretched + 1;
        if (i == 0 && run_len[i] > 2)
          long_half <= long_half + 1;
        run_len[i] <= 1;
      end else begin
        run_len[i] <= run_len[i] + 1;
      end
    end
    prev_bits <= clk_bits;
  end

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic compare_val(input string name, input int got, input int exp,
                             input int tol);
    int diff;
    diff = got - exp;
    if (diff < 0)
      diff = -diff;
    n_checks++;
    if (diff > tol) begin
      n_errors++;
      $display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    n_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic close_test(input int num, input string name);
    if (n_errors == test_err)
      $display("Test %0d %s: ok", num, name);
    else
      $display("Test %0d %s: %0d errors", num, name, n_errors - test_err);
    test_err = n_errors;
  endtask

  // 0..3 valid bits, 4 ready
  function automatic logic probe(int sel);
    if (sel == 4)
      return ast_ready_o;
    return val_bits[sel];
  endfunction

  task automatic wait_level(input int sel, input logic lvl, output int cyc);
    cyc = 0;
    while (probe(sel) != lvl && cyc <= WaitLim) begin
      @(negedge clk_sys_ext_i);
      cyc++;
    end
    if (probe(sel) != lvl)
      cyc = -1;  // Gave up
  endtask

  // Raise pok and time aon valid, first toggles and ready
  task automatic bring_up();
    int first [4];
    int aon_at;
    int rdy;
    for (int i = 0; i < 4; i++)
      first[i] = -1;
    aon_at = -1;
    rdy    = -1;
    vcore_pok_h_i = 1'b1;
    for (int cyc = 1; cyc <= StartLim && rdy < 0; cyc++) begin
      @(negedge clk_sys_ext_i);
      if (!val_bits[OSC_AON])  // Nothing else may run yet
        compare_val("clk_src_o[2:0] before aon", int'(clk_bits[2:0]), 0, 0);
      if (aon_at < 0 && val_bits[OSC_AON])
        aon_at = cyc;
      for (int i = 0; i < 4; i++)
        if (first[i] < 0 && clk_bits[i])
          first[i] = cyc;
      if (ast_ready_o)
        rdy = cyc;
    end
    if (aon_at < 0)
      report_error("aon valid never rose after power good");
    else
      compare_val("clk_val_o.aon rise cycle", aon_at, exp_first(3), 0);
    for (int i = 0; i < 3; i++)
      compare_val($sformatf("clk_src_o[%0d] first toggle", i), first[i], exp_first(i), 0);
    if (rdy < 0)
      report_error("ast_ready_o never rose after start-up");
    else
      compare_val("ast_ready_o rise cycle", rdy, exp_first(0) + 1, 0);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int got;
    int lo;
    int hi;
    int sel;
    int gap;
    int e0 [4];
    int h0 [4];
    int s0;
    int l0;
    reset_i       = 1'b1;
    vcore_pok_h_i = 1'b0;
    sys_en_i      = 1'b0;
    sys_jen_i     = 1'b0;
    io_en_i       = 1'b0;
    usb_en_i      = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    test_err      = 0;
    repeat (16) @(negedge clk_sys_ext_i);
    reset_i = 1'b0;

    // 1: requests up early, power still down
    sys_en_i = 1'b1;
    io_en_i  = 1'b1;
    usb_en_i = 1'b1;
    repeat (PdCycles) begin
      @(negedge clk_sys_ext_i);
      compare_val("clk_src_o", int'(clk_bits), 0, 0);
      compare_val("clk_val_o", int'(val_bits), 0, 0);
      compare_val("ast_ready_o", int'(ast_ready_o), 0, 0);
    end
    close_test(1, "power-down state");

    bring_up();
    close_test(2, "start-up order");

    // 3: rates over a fixed window
    for (int i = 0; i < 4; i++)
      e0[i] = edge_cnt[i];
    s0 = stretched;
    repeat (Win) @(negedge clk_sys_ext_i);
    for (int i = 0; i < 4; i++)
      compare_val($sformatf("clk_src_o[%0d] edges", i), edge_cnt[i] - e0[i],
                  exp_edges(div_of(i), Win), 1);
    compare_val("sys stretched halves", stretched - s0, 0, 0);
    close_test(3, "divider rates");

    // 4: io and usb dropped at random phases
    for (int i = 0; i < 4; i++)
      h0[i] = short_hi[i];
    for (int k = 0; k < NumDrops; k++) begin
      sel = (k % 2 == 0) ? 1 : 2;
      gap = $random(seed) & 15;
      repeat (gap) @(negedge clk_sys_ext_i);
      if (sel == 1)
        io_en_i = 1'b0;
      else
        usb_en_i = 1'b0;
      wait_level(4, 1'b0, got);
      if (got < 0)
        report_error("ast_ready_o stayed high after a source disable");
      wait_level(sel, 1'b0, got);
      if (got < 0)
        report_error("valid did not fall after a source disable");
      else
        compare_val($sformatf("clk_src_o[%0d] at stop", sel), int'(clk_bits[sel]), 0, 0);
      io_en_i  = 1'b1;
      usb_en_i = 1'b1;
      // Ready is legal while the dropped source is off, so its valid comes first
      wait_level(sel, 1'b1, got);
      if (got < 0)
        report_error("valid did not return after re-enable");
      wait_level(4, 1'b1, got);
      if (got < 0)
        report_error("ast_ready_o did not return after re-enable");
    end
    compare_val("io runt pulses", short_hi[1] - h0[1], 0, 0);
    compare_val("usb runt pulses", short_hi[2] - h0[2], 0, 0);
    close_test(4, "glitch-free stop");

    // 5: jittered sys, halves of 1 or 2 cycles
    sys_jen_i = 1'b1;
    e0[0] = edge_cnt[0];
    s0    = stretched;
    l0    = long_half;
    repeat (Win) @(negedge clk_sys_ext_i);
    lo = exp_edges(SysDiv + 1, Win);  // Every half stretched
    hi = exp_edges(SysDiv, Win);      // No stretch at all
    compare_val("sys jittered edges", edge_cnt[0] - e0[0], (lo + hi) / 2, (hi - lo) / 2);
    compare_val("sys stretch seen", int'(stretched > s0), 1, 0);
    compare_val("sys halves over 2 cycles", long_half - l0, 0, 0);
    sys_jen_i = 1'b0;
    close_test(5, "jitter");

    // 6: power loss while running, then a fresh bring-up
    vcore_pok_h_i = 1'b0;
    @(negedge clk_sys_ext_i);
    compare_val("clk_src_o after pok loss", int'(clk_bits), 0, 0);
    compare_val("clk_val_o after pok loss", int'(val_bits), 0, 0);
    compare_val("ast_ready_o after pok loss", int'(ast_ready_o), 0, 0);
    repeat (4) @(negedge clk_sys_ext_i);
    bring_up();
    close_test(6, "power loss");

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WdCycles * ClkPeriod);
    $display("Timeout: run did not end within %0d cycles", WdCycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule : ast_clks_tb

// File: ast_clks.f
hw/ast_clk_pkg.sv
hw/jitter_lfsr.sv
hw/osc_gen.sv
hw/osc_ctrl.sv
hw/ast_clks.sv
bench/ast_clks_assertions.sv
bench/ast_clks_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := ast_clks_tb
RTL_TOP    := ast_clks
FLIST      := ast_clks.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
